/* kbd_stimulus.txt */
# test <name> | ps2 <byte> <send 0/1> <tx byte> | tmo <tx byte> | rst
# mac <cmd> <reply> | caps <level>, all values in hex
test startup
tmo FF
ps2 12 1 FF
ps2 FA 0 00
ps2 AA 1 ED
ps2 33 1 FF
ps2 AA 1 ED
tmo FF
ps2 AA 1 ED
ps2 FA 1 02
ps2 55 1 FF
ps2 AA 1 ED
ps2 FA 1 02
tmo FF
ps2 AA 1 ED
ps2 FA 1 02
ps2 FA 0 00
test model_test
mac 16 03
mac 36 7D
test no_key
mac 14 7B
mac 10 7B
test translate
ps2 1C 0 00
mac 10 01
ps2 F0 0 00
ps2 1C 0 00
mac 10 81
ps2 E0 0 00
ps2 75 0 00
mac 10 79
mac 10 0B
ps2 07 0 00
mac 10 7B
test keypad
ps2 70 0 00
mac 10 79
mac 10 25
test capslock
caps 0
ps2 58 0 00
caps 1
mac 10 73
ps2 F0 0 00
ps2 58 0 00
caps 1
mac 10 7B
ps2 58 0 00
caps 0
mac 10 7B
ps2 F0 0 00
ps2 58 0 00
caps 0
mac 10 F3
test reset_leds
ps2 58 0 00
caps 1
rst
caps 0
ps2 AA 1 ED
ps2 FA 1 02
ps2 FA 0 00

/* verilog.f */
+incdir+.
kbd_pkg.sv
ps2_init_fsm.sv
pace_timer.sv
scan_decoder.sv
mac_reply.sv
ps2_mac_kbd.sv
tb_ps2_mac_kbd.sv

/* Makefile */
SRCS = kbd_defines.svh kbd_pkg.sv ps2_init_fsm.sv pace_timer.sv scan_decoder.sv \
	mac_reply.sv ps2_mac_kbd.sv tb_ps2_mac_kbd.sv

.PHONY: run clean

run: obj_dir/Vtb_ps2_mac_kbd
	./obj_dir/Vtb_ps2_mac_kbd | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

obj_dir/Vtb_ps2_mac_kbd: $(SRCS) verilog.f
	verilator --binary --timing --assert --top-module tb_ps2_mac_kbd -f verilog.f

clean:
	rm -rf obj_dir sim.log

/* tb_ps2_mac_kbd.sv */
`timescale 1ns/1ns
`include "kbd_defines.svh"

module tb_ps2_mac_kbd;

	localparam int WAIT_LIMIT = `PACE_LONG + 256; // Longest reply plus margin

	logic       sysclk;
	logic       reset;
	logic       rx_strobe;
	logic [7:0] rx_byte;
	logic       rx_timeout;
	logic       tx_req;
	logic [7:0] tx_byte;
	logic       mac_cmd_strobe;
	logic [7:0] mac_cmd;
	logic       mac_reply_strobe;
	logic [7:0] mac_reply;
	logic       capslock;

	int    errors;
	int    checks;
	int    tests;
	int    test_errors;
	string name;

	ps2_mac_kbd i_dut (
		.sysclk           (sysclk),
		.reset            (reset),
		.rx_strobe        (rx_strobe),
		.rx_byte          (rx_byte),
		.rx_timeout       (rx_timeout),
		.tx_req           (tx_req),
		.tx_byte          (tx_byte),
		.mac_cmd_strobe   (mac_cmd_strobe),
		.mac_cmd          (mac_cmd),
		.mac_reply_strobe (mac_reply_strobe),
		.mac_reply        (mac_reply),
		.capslock         (capslock)
	);

	initial begin
		sysclk = 1'b0;
		forever #10 sysclk = ~sysclk; // 20 ns period
	end

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic check_value(input string sig, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s expected %h, got %h", $time, sig, expected, actual);
			note_error();
		end
	endtask

	task automatic apply_reset();
		@(negedge sysclk);
		reset = 1'b1;
		repeat (10) @(negedge sysclk);
		reset = 1'b0;
	endtask

	// tx_req is registered, so it shows at the negedge after the event
	task automatic wait_tx(input logic [7:0] expected);
		int cycles;
		cycles = 0;
		while (!tx_req && cycles < WAIT_LIMIT) begin
			@(negedge sysclk);
			cycles++;
		end
		if (tx_req) begin
			check_value("tx_byte", expected, tx_byte);
		end else begin
			$display("Timeout at %0d ns: no PS/2 send request arrived", $time);
			note_error();
		end
	endtask

	task automatic send_ps2(input logic [7:0] data, input logic want_tx,
		input logic [7:0] expected);
		@(negedge sysclk);
		rx_byte = data;
		rx_strobe = 1'b1;
		@(negedge sysclk);
		rx_strobe = 1'b0;
		if (want_tx) begin
			wait_tx(expected);
		end else begin
			check_value("tx_req", 8'h00, {7'b0, tx_req}); // Would show by now
		end
	endtask

	task automatic line_timeout(input logic [7:0] expected);
		@(negedge sysclk);
		rx_timeout = 1'b1;
		@(negedge sysclk);
		rx_timeout = 1'b0;
		wait_tx(expected);
	endtask

	task automatic send_mac(input logic [7:0] cmd, input logic [7:0] expected);
		int cycles;
		@(negedge sysclk);
		mac_cmd = cmd;
		mac_cmd_strobe = 1'b1;
		@(negedge sysclk);
		mac_cmd_strobe = 1'b0;
		cycles = 0;
		while (!mac_reply_strobe && cycles < WAIT_LIMIT) begin
			@(negedge sysclk);
			cycles++;
		end
		if (mac_reply_strobe) begin
			check_value("mac_reply", expected, mac_reply);
		end else begin
			$display("Timeout at %0d ns: no reply to Mac command %h", $time, cmd);
			note_error();
		end
	endtask

	task automatic close_test();
		if (name != "") begin
			if (test_errors == 0) begin
				$display("test %s: ok", name);
			end else begin
				$display("test %s: %0d errors", name, test_errors);
			end
		end
		test_errors = 0;
	endtask

	task automatic bad_line(input string op);
		$display("Stimulus line for %s has missing or malformed operands", op);
		note_error();
	endtask

	initial begin : run_stimulus
		int               fd;
		int               n;
		logic             done;
		string            op;
		logic [7:0]       a;
		logic [7:0]       f;
		logic [7:0]       b;
		logic [8*128-1:0] rest;
		reset = 1'b1;
		rx_strobe = 1'b0;
		rx_byte = 8'h00;
		rx_timeout = 1'b0;
		mac_cmd_strobe = 1'b0;
		mac_cmd = 8'h00;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors = 0;
		name = "";
		done = 1'b0;
		apply_reset();
		fd = $fopen("kbd_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file kbd_stimulus.txt");
			errors++;
		end else begin
			while (!done) begin
				n = $fscanf(fd, "%s", op);
				if (n != 1) begin
					done = 1'b1; // End of file
				end else if (op == "#") begin
					n = $fgets(rest, fd); // Comment line
				end else if (op == "test") begin
					close_test();
					n = $fscanf(fd, "%s", name);
					tests++;
				end else if (op == "ps2") begin
					n = $fscanf(fd, "%h %h %h", a, f, b);
					if (n == 3) send_ps2(a, f != 8'h00, b);
					else bad_line(op);
				end else if (op == "tmo") begin
					n = $fscanf(fd, "%h", b);
					if (n == 1) line_timeout(b);
					else bad_line(op);
				end else if (op == "mac") begin
					n = $fscanf(fd, "%h %h", a, b);
					if (n == 2) send_mac(a, b);
					else bad_line(op);
				end else if (op == "caps") begin
					n = $fscanf(fd, "%h", b);
					if (n == 1) check_value("capslock", b, {7'b0, capslock});
					else bad_line(op);
				end else if (op == "rst") begin
					apply_reset();
				end else begin
					$display("Unknown operation %s in the stimulus file", op);
					note_error();
				end
			end
			$fclose(fd);
		end
		close_test();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* ps2_mac_kbd.sv */
`timescale 1ns/1ns

module ps2_mac_kbd (
	input  logic       sysclk,
	input  logic       reset,
	input  logic       rx_strobe,
	input  logic [7:0] rx_byte,
	input  logic       rx_timeout,
	output logic       tx_req,
	output logic [7:0] tx_byte,
	input  logic       mac_cmd_strobe,
	input  logic [7:0] mac_cmd,
	output logic       mac_reply_strobe,
	output logic [7:0] mac_reply,
	output logic       capslock
);

	logic               kbd_ready;
	logic               key_event;
	kbd_pkg::mac_code_t key_code;
	logic               tick_short;
	logic               tick_long;

	ps2_init_fsm i_init_fsm (
		.sysclk     (sysclk),
		.reset      (reset),
		.rx_strobe  (rx_strobe),
		.rx_byte    (rx_byte),
		.rx_timeout (rx_timeout),
		.capslock   (capslock),
		.kbd_ready  (kbd_ready),
		.tx_req     (tx_req),
		.tx_byte    (tx_byte)
	);

	scan_decoder i_scan_decoder (
		.sysclk    (sysclk),
		.reset     (reset),
		.rx_strobe (rx_strobe),
		.rx_byte   (rx_byte),
		.kbd_ready (kbd_ready),
		.key_event (key_event),
		.key_code  (key_code),
		.capslock  (capslock)
	);

	pace_timer i_pace_timer (
		.sysclk     (sysclk),
		.reset      (reset),
		.restart    (mac_cmd_strobe), // Every command restarts pacing
		.tick_short (tick_short),
		.tick_long  (tick_long)
	);

	mac_reply i_mac_reply (
		.sysclk           (sysclk),
		.reset            (reset),
		.mac_cmd_strobe   (mac_cmd_strobe),
		.mac_cmd          (mac_cmd),
		.key_event        (key_event),
		.key_code         (key_code),
		.tick_short       (tick_short),
		.tick_long        (tick_long),
		.mac_reply_strobe (mac_reply_strobe),
		.mac_reply        (mac_reply)
	);

endmodule

/* mac_reply.sv */
`timescale 1ns/1ns
`include "kbd_defines.svh"

module mac_reply (
	input  logic               sysclk,
	input  logic               reset,
	input  logic               mac_cmd_strobe,
	input  kbd_pkg::mac_byte_t mac_cmd,
	input  logic               key_event,
	input  kbd_pkg::mac_code_t key_code,
	input  logic               tick_short,
	input  logic               tick_long,
	output logic               mac_reply_strobe,
	output kbd_pkg::mac_byte_t mac_reply
);

	logic               cmd_inquiry;
	logic               cmd_instant;
	logic               cmd_model;
	logic               cmd_test;
	logic               inquiry_active;
	logic               key_pending;
	logic               keypad_byte2;
	logic               pop_key;
	kbd_pkg::mac_code_t key_slot;

	// Latch the last command, unknown bytes leave no flag set
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			cmd_inquiry <= 1'b0;
			cmd_instant <= 1'b0;
			cmd_model <= 1'b0;
			cmd_test <= 1'b0;
		end else if (mac_cmd_strobe) begin
			cmd_inquiry <= (mac_cmd == `MAC_CMD_INQUIRY);
			cmd_instant <= (mac_cmd == `MAC_CMD_INSTANT);
			cmd_model <= (mac_cmd == `MAC_CMD_MODEL);
			cmd_test <= (mac_cmd == `MAC_CMD_TEST);
		end
	end

	// Inquiry waits for a key or the long tick
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			inquiry_active <= 1'b0;
		else if (mac_cmd_strobe || mac_reply_strobe)
			inquiry_active <= 1'b0;
		else if (tick_short)
			inquiry_active <= cmd_inquiry;
	end

	assign pop_key = (cmd_instant && tick_short) ||
		(inquiry_active && (tick_long || key_pending));

	assign mac_reply_strobe = ((cmd_model || cmd_test) && tick_short) || pop_key;

	// Keypad keys take two pops, the slot stays full after the first
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			key_pending <= 1'b0;
			keypad_byte2 <= 1'b0;
		end else if (pop_key && key_pending) begin
			if (key_slot[8] && !keypad_byte2) begin
				keypad_byte2 <= 1'b1;
			end else begin
				key_pending <= 1'b0;
				keypad_byte2 <= 1'b0;
			end
		end else if (key_event && !key_pending) begin
			key_pending <= 1'b1;
		end
	end

	always_ff @(posedge sysclk) begin
		if (key_event && !key_pending)
			key_slot <= key_code; // Keys arriving on a full slot are dropped
	end

	always_comb begin
		if (cmd_test)
			mac_reply = `MAC_REPLY_TEST;
		else if (cmd_model)
			mac_reply = `MAC_REPLY_MODEL;
		else if (key_pending && key_slot[8] && !keypad_byte2)
			mac_reply = `MAC_REPLY_KEYPAD;
		else if (key_pending)
			mac_reply = key_slot[7:0];
		else
			mac_reply = `MAC_REPLY_NULL;
	end

	a_byte2_needs_key: assert property (@(posedge sysclk) disable iff (reset)
		keypad_byte2 |-> key_pending);

endmodule

/* scan_decoder.sv */
`timescale 1ns/1ns
`include "kbd_defines.svh"

module scan_decoder (
	input  logic                sysclk,
	input  logic                reset,
	input  logic                rx_strobe,
	input  kbd_pkg::scan_byte_t rx_byte,
	input  logic                kbd_ready,
	output logic                key_event,
	output kbd_pkg::mac_code_t  key_code,
	output logic                capslock
);

	logic               got_byte;
	logic               is_break;
	logic               is_extend;
	logic               ignore_caps;
	logic               keybreak;
	logic               extended;
	kbd_pkg::mac_code_t table_code;

	assign got_byte = kbd_ready && rx_strobe;
	assign is_break = ({rx_byte[7:1], 1'b0} == `PS2_BREAK); // F0 or F1
	assign is_extend = ({rx_byte[7:1], 1'b0} == `PS2_EXTEND); // E0 or E1
	// Mac caps key latches, so a second press while on is not reported
	assign ignore_caps = !extended && rx_byte == `SCAN_CAPSLOCK && capslock;

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			keybreak <= 1'b0;
			extended <= 1'b0;
			capslock <= 1'b0;
		end else if (got_byte) begin
			if (is_break) begin
				keybreak <= 1'b1;
			end else if (is_extend) begin
				extended <= 1'b1;
			end else begin
				keybreak <= 1'b0;
				extended <= 1'b0;
				if (rx_byte == `SCAN_CAPSLOCK && !keybreak)
					capslock <= ~capslock; // Toggle on press only
			end
		end
	end

	assign key_event = got_byte && !is_break && !is_extend && !ignore_caps;

	// Scan Code Set 2, Mac codes already shifted left with bit 0 set
	always_comb begin
		case ({extended, rx_byte})
			9'h00d: table_code = 9'h061; // Tab
			9'h00e: table_code = 9'h065; // Backtick
			9'h011: table_code = 9'h06f; // Left alt as command
			9'h012: table_code = 9'h071; // Left shift
			9'h015: table_code = 9'h019; // Q
			9'h016: table_code = 9'h025; // 1
			9'h01a: table_code = 9'h00d; // Z
			9'h01b: table_code = 9'h003; // S
			9'h01c: table_code = 9'h001; // A
			9'h01d: table_code = 9'h01b; // W
			9'h01e: table_code = 9'h027; // 2
			9'h021: table_code = 9'h011; // C
			9'h022: table_code = 9'h00f; // X
			9'h023: table_code = 9'h005; // D
			9'h024: table_code = 9'h01d; // E
			9'h025: table_code = 9'h02b; // 4
			9'h026: table_code = 9'h029; // 3
			9'h029: table_code = 9'h063; // Space
			9'h02a: table_code = 9'h013; // V
			9'h02b: table_code = 9'h007; // F
			9'h02c: table_code = 9'h023; // T
			9'h02d: table_code = 9'h01f; // R
			9'h02e: table_code = 9'h02f; // 5
			9'h031: table_code = 9'h05b; // N
			9'h032: table_code = 9'h017; // B
			9'h033: table_code = 9'h009; // H
			9'h034: table_code = 9'h00b; // G
			9'h035: table_code = 9'h021; // Y
			9'h036: table_code = 9'h02d; // 6
			9'h03a: table_code = 9'h05d; // M
			9'h03b: table_code = 9'h04d; // J
			9'h03c: table_code = 9'h041; // U
			9'h03d: table_code = 9'h035; // 7
			9'h03e: table_code = 9'h039; // 8
			9'h041: table_code = 9'h057; // Comma
			9'h042: table_code = 9'h051; // K
			9'h043: table_code = 9'h045; // I
			9'h044: table_code = 9'h03f; // O
			9'h045: table_code = 9'h03b; // 0
			9'h046: table_code = 9'h033; // 9
			9'h049: table_code = 9'h05f; // Period
			9'h04a: table_code = 9'h059; // Slash
			9'h04b: table_code = 9'h04b; // L
			9'h04c: table_code = 9'h053; // Semicolon
			9'h04d: table_code = 9'h047; // P
			9'h04e: table_code = 9'h037; // Minus
			9'h052: table_code = 9'h04f; // Quote
			9'h054: table_code = 9'h043; // Left bracket
			9'h055: table_code = 9'h031; // Equals
			9'h058: table_code = 9'h073; // Caps lock
			9'h059: table_code = 9'h071; // Right shift
			9'h05a: table_code = 9'h049; // Enter
			9'h05b: table_code = 9'h03d; // Right bracket
			9'h05d: table_code = 9'h055; // Backslash
			9'h066: table_code = 9'h067; // Backspace
			9'h069: table_code = 9'h127; // KP 1
			9'h06b: table_code = 9'h12d; // KP 4
			9'h06c: table_code = 9'h133; // KP 7
			9'h070: table_code = 9'h125; // KP 0
			9'h071: table_code = 9'h103; // KP point
			9'h072: table_code = 9'h129; // KP 2
			9'h073: table_code = 9'h12f; // KP 5
			9'h074: table_code = 9'h131; // KP 6
			9'h075: table_code = 9'h137; // KP 8
			9'h079: table_code = 9'h10d; // KP plus
			9'h07a: table_code = 9'h12b; // KP 3
			9'h07b: table_code = 9'h11d; // KP minus
			9'h07c: table_code = 9'h105; // KP star
			9'h07d: table_code = 9'h139; // KP 9
			9'h111: table_code = 9'h06f; // Right alt as command
			9'h11f: table_code = 9'h075; // Windows key as option
			9'h14a: table_code = 9'h11b; // KP slash
			9'h15a: table_code = 9'h119; // KP enter
			9'h16b: table_code = 9'h10d; // Left arrow
			9'h172: table_code = 9'h111; // Down arrow
			9'h174: table_code = 9'h105; // Right arrow
			9'h175: table_code = 9'h10b; // Up arrow
			default: table_code = {1'b0, `MAC_REPLY_NULL};
		endcase
	end

	assign key_code = {table_code[8], keybreak, table_code[6:0]}; // Bit 7 is key up

	a_event_on_strobe: assert property (@(posedge sysclk) disable iff (reset)
		key_event |-> rx_strobe);

endmodule

/* pace_timer.sv */
`timescale 1ns/1ns
`include "kbd_defines.svh"

module pace_timer (
	input  logic sysclk,
	input  logic reset,
	input  logic restart,
	output logic tick_short,
	output logic tick_long
);

	kbd_pkg::pace_count_t count;

	// Restarts on every Mac command, saturates at the long limit
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset)
			count <= '0;
		else if (restart)
			count <= '0;
		else if (!tick_long)
			count <= count + 1'b1;
	end

	assign tick_short = (count == kbd_pkg::pace_count_t'(`PACE_SHORT)); // Single cycle
	assign tick_long = (count == kbd_pkg::pace_count_t'(`PACE_LONG)); // Level while held

	a_ticks_apart: assert property (@(posedge sysclk) disable iff (reset)
		!(tick_short && tick_long));

endmodule

/* ps2_init_fsm.sv */
`timescale 1ns/1ns
`include "kbd_defines.svh"

module ps2_init_fsm (
	input  logic                sysclk,
	input  logic                reset,
	input  logic                rx_strobe,
	input  kbd_pkg::scan_byte_t rx_byte,
	input  logic                rx_timeout,
	input  logic                capslock,
	output logic                kbd_ready,
	output logic                tx_req,
	output kbd_pkg::scan_byte_t tx_byte
);

	kbd_pkg::ps2k_state_t state;
	kbd_pkg::ps2k_state_t next;
	logic                 nreq;
	kbd_pkg::scan_byte_t  nbyte;

	// Next state and the byte to send, only on a strobe or a timeout
	always_comb begin
		next = state;
		nreq = 1'b0;
		nbyte = `PS2_RESET;
		if (rx_strobe || rx_timeout) begin
			case (state)
				kbd_pkg::INIT: begin
					if (rx_strobe && rx_byte == `PS2_BAT_OK) begin
						nreq = 1'b1;
						nbyte = `PS2_SET_LED;
						next = kbd_pkg::LED1;
					end else if (!rx_strobe || rx_byte != `PS2_ACK) begin
						nreq = 1'b1; // Stray ack is ignored
					end
				end
				kbd_pkg::LED1: begin
					nreq = 1'b1;
					if (rx_strobe && rx_byte == `PS2_ACK) begin
						nbyte = {5'b00000, capslock, 1'b1, 1'b0};
						next = kbd_pkg::LED2;
					end else begin
						next = kbd_pkg::INIT;
					end
				end
				kbd_pkg::LED2: begin
					if (rx_strobe && rx_byte == `PS2_ACK) begin
						next = kbd_pkg::WAIT;
					end else begin
						nreq = 1'b1;
						next = kbd_pkg::INIT;
					end
				end
				kbd_pkg::WAIT: next = kbd_pkg::WAIT; // Scan codes go to the decoder
			endcase
		end
	end

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state <= kbd_pkg::INIT;
			tx_req <= 1'b0;
		end else begin
			state <= next;
			tx_req <= nreq;
		end
	end

	always_ff @(posedge sysclk) begin
		tx_byte <= nbyte; // Qualified by tx_req
	end

	assign kbd_ready = (state == kbd_pkg::WAIT);

	// Byte layer never delivers events on back-to-back cycles
	a_req_single: assert property (@(posedge sysclk) disable iff (reset)
		tx_req |=> !tx_req);

	a_wait_sticky: assert property (@(posedge sysclk) disable iff (reset)
		state == kbd_pkg::WAIT |=> state == kbd_pkg::WAIT);

endmodule

/* kbd_pkg.sv */
`include "kbd_defines.svh"

package kbd_pkg;

	typedef logic [7:0] scan_byte_t; // PS/2 byte, in or out

	typedef logic [7:0] mac_byte_t; // Mac command or reply

	// [8] keypad, [7] key up, [6:0] Mac key code
	typedef logic [8:0] mac_code_t;

	typedef enum logic [1:0] {
		INIT, // Wait for self-test byte
		LED1, // Wait for ack of set-LED
		LED2, // Wait for ack of LED byte
		WAIT  // Keyboard up, scan codes flow
	} ps2k_state_t;

	typedef logic [`PACE_BITS-1:0] pace_count_t;

endpackage

/* kbd_defines.svh */
`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// Bytes seen on the PS/2 side
`define PS2_BAT_OK       8'hAA // Self-test passed
`define PS2_ACK          8'hFA
`define PS2_SET_LED      8'hED
`define PS2_RESET        8'hFF
`define PS2_BREAK        8'hF0 // Release prefix, F1 matches too
`define PS2_EXTEND       8'hE0 // Extended prefix, E1 matches too
`define SCAN_CAPSLOCK    8'h58

// Commands from the Mac
`define MAC_CMD_INQUIRY  8'h10
`define MAC_CMD_INSTANT  8'h14
`define MAC_CMD_MODEL    8'h16
`define MAC_CMD_TEST     8'h36

// Replies to the Mac
`define MAC_REPLY_TEST   8'h7D
`define MAC_REPLY_MODEL  8'h03
`define MAC_REPLY_KEYPAD 8'h79 // First byte of a keypad key
`define MAC_REPLY_NULL   8'h7B // No key

// Reply pacing, in sysclk cycles after a command
`define PACE_BITS        12
`define PACE_SHORT       63   // Earliest reply
`define PACE_LONG        4095 // Inquiry gives up, counter all ones

`endif
